// File: rtl/pcxt_pkg.sv
// pcxt front end shared definitions
// widths, apb register map, tint codes, splash length
// and the luma weight tables of the mono video path
package pcxt_pkg;

	////////////////////
	// widths
	////////////////////
	typedef logic [5:0] color_t;
	typedef logic [3:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;
	typedef logic signed [15:0] sample_t;
	typedef logic [7:0] tandy_t;
	typedef logic [2:0] sec_count_t;

	// tint codes, same order as the old osd menu
	typedef enum logic [1:0] {
		TINT_COLOR = 2'd0,
		TINT_GREEN = 2'd1,
		TINT_AMBER = 2'd2,
		TINT_BW    = 2'd3
	} tint_e;

	typedef enum logic {
		ST_SPLASH = 1'b0,
		ST_RUN    = 1'b1
	} splash_state_e;

	////////////////////
	// register map
	////////////////////
	localparam apb_addr_t ADDR_CTRL = 4'h0;
	localparam apb_addr_t ADDR_STATUS = 4'h4;

	// ctrl field positions, tint is two bits wide
	localparam int CTRL_SOFT_RESET = 0;
	localparam int CTRL_SPLASH_SKIP = 1;
	localparam int CTRL_VIDEO_MDA = 2;
	localparam int CTRL_TINT_LSB = 3;

	// cpu held in reset this long after power up
	localparam sec_count_t SPLASH_SECONDS = 3'd5;

	////////////////////
	// luma weights
	////////////////////
	// 0.2126 * r
	localparam color_t RED_WEIGHT [0:63] = '{
		0, 1, 1, 1, 1, 2, 2, 2, 2, 2, 3, 3, 3, 3, 3, 4,
		4, 4, 4, 5, 5, 5, 5, 5, 6, 6, 6, 6, 6, 7, 7, 7,
		7, 8, 8, 8, 8, 8, 9, 9, 9, 9, 9, 10, 10, 10, 10, 10,
		11, 11, 11, 11, 12, 12, 12, 12, 12, 13, 13, 13, 13, 13, 14, 14
	};

	// 0.7152 * g, flattens out near the top
	localparam color_t GREEN_WEIGHT [0:63] = '{
		0, 1, 2, 3, 3, 4, 5, 6, 6, 7, 8, 8, 9, 10, 11, 11,
		12, 13, 13, 14, 15, 16, 16, 17, 18, 18, 19, 20, 21, 21, 22, 23,
		23, 24, 25, 26, 26, 27, 28, 28, 29, 30, 31, 31, 32, 33, 33, 34,
		35, 36, 36, 37, 38, 38, 39, 40, 41, 41, 42, 42, 42, 43, 43, 43
	};

	// 0.0722 * b
	localparam color_t BLUE_WEIGHT [0:63] = '{
		0, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 2, 2,
		2, 2, 2, 2, 2, 2, 2, 2, 2, 2, 2, 2, 3, 3, 3, 3,
		3, 3, 3, 3, 3, 3, 3, 3, 3, 3, 4, 4, 4, 4, 4, 4,
		4, 4, 4, 4, 4, 4, 4, 4, 5, 5, 5, 5, 5, 5, 5, 5
	};

endpackage

// File: rtl/cfg_regs.sv
// configuration registers
// apb slave, zero wait states, holding the control word
// (soft reset, splash skip, video select, tint) and a
// read-only status word with cpu hold and elapsed seconds
`timescale 1ns/1ps

module cfg_regs (
	input  logic                 CLOCK_27,
	input  logic                 reset,
	input  logic                 psel,
	input  logic                 penable,
	input  logic                 pwrite,
	input  pcxt_pkg::apb_addr_t  paddr,
	input  pcxt_pkg::apb_data_t  pwdata,
	input  logic                 cpu_hold,
	input  pcxt_pkg::sec_count_t seconds,
	output pcxt_pkg::apb_data_t  prdata,
	output logic                 pready,
	output logic                 pslverr,
	output logic                 soft_reset,
	output logic                 splash_skip,
	output logic                 video_mda,
	output pcxt_pkg::tint_e      tint
);

	logic access;
	logic hit_ctrl;
	logic hit_status;
	logic wr_ctrl;

	// access phase and address decode
	assign access = psel && penable;
	assign hit_ctrl = (paddr == pcxt_pkg::ADDR_CTRL);
	assign hit_status = (paddr == pcxt_pkg::ADDR_STATUS);
	assign wr_ctrl = access && pwrite && hit_ctrl;

	// no wait states
	assign pready = 1'b1;

	// unmapped address, or write to read-only status
	assign pslverr = access && (!(hit_ctrl || hit_status) || (pwrite && hit_status));

	////////////////////
	// control word
	////////////////////
	always_ff @(posedge CLOCK_27) begin
		if (reset) begin
			soft_reset <= 1'b0;
			splash_skip <= 1'b0;
			video_mda <= 1'b0;
			tint <= pcxt_pkg::TINT_COLOR;
		end else begin
			// soft reset only lives for one cycle
			soft_reset <= wr_ctrl && pwdata[pcxt_pkg::CTRL_SOFT_RESET];
			if (wr_ctrl) begin
				splash_skip <= pwdata[pcxt_pkg::CTRL_SPLASH_SKIP];
				video_mda <= pwdata[pcxt_pkg::CTRL_VIDEO_MDA];
				tint <= pcxt_pkg::tint_e'(pwdata[pcxt_pkg::CTRL_TINT_LSB +: 2]);
			end
		end
	end

	// read mux, soft reset bit reads as 0
	always_comb begin
		prdata = '0;
		if (psel && !pwrite) begin
			if (hit_ctrl) begin
				prdata[pcxt_pkg::CTRL_SPLASH_SKIP] = splash_skip;
				prdata[pcxt_pkg::CTRL_VIDEO_MDA] = video_mda;
				prdata[pcxt_pkg::CTRL_TINT_LSB +: 2] = tint;
			end else if (hit_status) begin
				prdata[0] = cpu_hold;
				prdata[3:1] = seconds;
			end
		end
	end

	// error response only in an access phase right after its setup phase
	a_pslverr_access: assert property (@(posedge CLOCK_27) disable iff (reset)
		pslverr |-> $past(psel && !penable));

endmodule

// File: rtl/splash_fsm.sv
// splash sequencer
// holds the cpu in reset after power up until the
// splash period runs out or is skipped
`timescale 1ns/1ps

module splash_fsm (
	input  logic                 CLOCK_27,
	input  logic                 reset,
	input  logic                 soft_reset,
	input  logic                 splash_skip,
	input  pcxt_pkg::sec_count_t seconds,
	output logic                 cpu_hold,
	output logic                 timer_run
);

	pcxt_pkg::splash_state_e state;
	pcxt_pkg::splash_state_e state_nxt;

	// count seconds only while the splash is up
	assign timer_run = (state == pcxt_pkg::ST_SPLASH);

	always_comb begin
		state_nxt = state;
		case (state)
			pcxt_pkg::ST_SPLASH: begin
				if (splash_skip || (seconds >= pcxt_pkg::SPLASH_SECONDS))
					state_nxt = pcxt_pkg::ST_RUN;
			end
			// run is left only through a reset
			default: state_nxt = pcxt_pkg::ST_RUN;
		endcase
		// soft reset wins over everything
		if (soft_reset)
			state_nxt = pcxt_pkg::ST_SPLASH;
	end

	always_ff @(posedge CLOCK_27) begin
		if (reset) begin
			state <= pcxt_pkg::ST_SPLASH;
			cpu_hold <= 1'b1;
		end else begin
			state <= state_nxt;
			cpu_hold <= (state_nxt == pcxt_pkg::ST_SPLASH);
		end
	end

	// splash never outlasts its length while the timer runs
	a_run_in_splash: assert property (@(posedge CLOCK_27) disable iff (reset)
		timer_run |-> (seconds <= pcxt_pkg::SPLASH_SECONDS));

endmodule

// File: rtl/second_timer.sv
// second timer
// prescaler turns clock cycles into whole seconds,
// seconds counter saturates at 7
`timescale 1ns/1ps

module second_timer #(
	parameter int TICKS_PER_SECOND = 14318000
) (
	input  logic                 CLOCK_27,
	input  logic                 reset,
	input  logic                 clear,
	input  logic                 run,
	output pcxt_pkg::sec_count_t seconds
);

	typedef logic [$clog2(TICKS_PER_SECOND)-1:0] presc_t;

	presc_t presc;
	logic   sec_tick;

	// last cycle of a second
	assign sec_tick = run && (presc == presc_t'(TICKS_PER_SECOND - 1));

	always_ff @(posedge CLOCK_27) begin
		if (reset || clear) begin
			presc <= '0;
			seconds <= '0;
		end else if (sec_tick) begin
			presc <= '0;
			// hold at max
			if (seconds != 3'd7)
				seconds <= seconds + 3'd1;
		end else if (run) begin
			presc <= presc + 1'b1;
		end
	end

endmodule

// File: rtl/mono_tint.sv
// monochrome video tint
// cga mode passes the colour through, mda mode turns
// the pixel into luma and paints it green, amber or
// grey, one register stage
`timescale 1ns/1ps

module mono_tint (
	input  logic             CLOCK_27,
	input  logic             reset,
	input  logic             video_mda,
	input  pcxt_pkg::tint_e  tint,
	input  pcxt_pkg::color_t pix_r,
	input  pcxt_pkg::color_t pix_g,
	input  pcxt_pkg::color_t pix_b,
	output pcxt_pkg::color_t out_r,
	output pcxt_pkg::color_t out_g,
	output pcxt_pkg::color_t out_b
);

	pcxt_pkg::color_t luma;
	pcxt_pkg::color_t nxt_r;
	pcxt_pkg::color_t nxt_g;
	pcxt_pkg::color_t nxt_b;

	// weighted sum, wraps at 6 bits
	assign luma = pcxt_pkg::RED_WEIGHT[pix_r] + pcxt_pkg::GREEN_WEIGHT[pix_g]
		+ pcxt_pkg::BLUE_WEIGHT[pix_b];

	////////////////////
	// tint select
	////////////////////
	always_comb begin
		// raw colour unless a mono tint applies
		nxt_r = pix_r;
		nxt_g = pix_g;
		nxt_b = pix_b;
		if (video_mda) begin
			case (tint)
				pcxt_pkg::TINT_GREEN: begin
					nxt_r = '0;
					nxt_g = luma;
					nxt_b = '0;
				end
				pcxt_pkg::TINT_AMBER: begin
					// half green gives the amber hue
					nxt_r = luma;
					nxt_g = luma >> 1;
					nxt_b = '0;
				end
				pcxt_pkg::TINT_BW: begin
					nxt_r = luma;
					nxt_g = luma;
					nxt_b = luma;
				end
				default: begin
					nxt_r = pix_r;
					nxt_g = pix_g;
					nxt_b = pix_b;
				end
			endcase
		end
	end

	// output stage
	always_ff @(posedge CLOCK_27) begin
		if (reset) begin
			out_r <= '0;
			out_g <= '0;
			out_b <= '0;
		end else begin
			out_r <= nxt_r;
			out_g <= nxt_g;
			out_b <= nxt_b;
		end
	end

endmodule

// File: rtl/audio_mix.sv
// signed audio mixer
// sums opl2, tandy and pc speaker into one 16-bit sample
`timescale 1ns/1ps

module audio_mix (
	input  logic              CLOCK_27,
	input  logic              reset,
	input  pcxt_pkg::sample_t opl_snd,
	input  pcxt_pkg::tandy_t  tandy_snd,
	input  logic              speaker,
	output pcxt_pkg::sample_t mix_out
);

	logic [16:0] sum;

	// opl2 sign extended, speaker near full scale,
	// tandy in the middle bits
	assign sum = ({opl_snd[15], opl_snd} << 2) + (17'(speaker) << 15)
		+ (17'(tandy_snd) << 8);

	// drop lsb, keep 16 bits
	always_ff @(posedge CLOCK_27) begin
		if (reset)
			mix_out <= '0;
		else
			mix_out <= pcxt_pkg::sample_t'(sum[16:1]);
	end

endmodule

// File: rtl/pcxt_frontend.sv
// pcxt front end top
// apb config registers, splash control for the cpu
// reset, mono video tint and the audio mixer
`timescale 1ns/1ps

module pcxt_frontend #(
	parameter int TICKS_PER_SECOND = 14318000
) (
	input  logic                CLOCK_27,
	input  logic                reset,
	input  logic                psel,
	input  logic                penable,
	input  logic                pwrite,
	input  pcxt_pkg::apb_addr_t paddr,
	input  pcxt_pkg::apb_data_t pwdata,
	output pcxt_pkg::apb_data_t prdata,
	output logic                pready,
	output logic                pslverr,
	input  pcxt_pkg::color_t    pix_r,
	input  pcxt_pkg::color_t    pix_g,
	input  pcxt_pkg::color_t    pix_b,
	output pcxt_pkg::color_t    out_r,
	output pcxt_pkg::color_t    out_g,
	output pcxt_pkg::color_t    out_b,
	input  pcxt_pkg::sample_t   opl_snd,
	input  pcxt_pkg::tandy_t    tandy_snd,
	input  logic                speaker,
	output pcxt_pkg::sample_t   mix_out,
	output logic                cpu_hold
);

	logic                 soft_reset;
	logic                 splash_skip;
	logic                 video_mda;
	pcxt_pkg::tint_e      tint;
	logic                 timer_run;
	pcxt_pkg::sec_count_t seconds;

	////////////////////
	// control
	////////////////////
	cfg_regs cfg_regs_i (
		.CLOCK_27    (CLOCK_27),
		.reset       (reset),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.cpu_hold    (cpu_hold),
		.seconds     (seconds),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.soft_reset  (soft_reset),
		.splash_skip (splash_skip),
		.video_mda   (video_mda),
		.tint        (tint)
	);

	splash_fsm splash_fsm_i (
		.CLOCK_27    (CLOCK_27),
		.reset       (reset),
		.soft_reset  (soft_reset),
		.splash_skip (splash_skip),
		.seconds     (seconds),
		.cpu_hold    (cpu_hold),
		.timer_run   (timer_run)
	);

	// soft reset also restarts the count
	second_timer #(
		.TICKS_PER_SECOND (TICKS_PER_SECOND)
	) second_timer_i (
		.CLOCK_27 (CLOCK_27),
		.reset    (reset),
		.clear    (soft_reset),
		.run      (timer_run),
		.seconds  (seconds)
	);

	////////////////////
	// data paths
	////////////////////
	mono_tint mono_tint_i (
		.CLOCK_27  (CLOCK_27),
		.reset     (reset),
		.video_mda (video_mda),
		.tint      (tint),
		.pix_r     (pix_r),
		.pix_g     (pix_g),
		.pix_b     (pix_b),
		.out_r     (out_r),
		.out_g     (out_g),
		.out_b     (out_b)
	);

	audio_mix audio_mix_i (
		.CLOCK_27  (CLOCK_27),
		.reset     (reset),
		.opl_snd   (opl_snd),
		.tandy_snd (tandy_snd),
		.speaker   (speaker),
		.mix_out   (mix_out)
	);

endmodule

// File: bench/pcxt_frontend_tb.sv
// pcxt front end testbench
// splash timing, soft reset and skip over apb, random register
// accesses, then random video and audio checked against a model
`timescale 1ns/1ps

module pcxt_frontend_tb;

	localparam int TICKS = 20;
	localparam int SPLASH_CYCLES = pcxt_pkg::SPLASH_SECONDS * TICKS;
	// full sequence needs a bit under 1000 cycles
	localparam int MAX_CYCLES = 2000;

	logic                CLOCK_27;
	logic                reset;
	logic                psel;
	logic                penable;
	logic                pwrite;
	pcxt_pkg::apb_addr_t paddr;
	pcxt_pkg::apb_data_t pwdata;
	pcxt_pkg::apb_data_t prdata;
	logic                pready;
	logic                pslverr;
	pcxt_pkg::color_t    pix_r;
	pcxt_pkg::color_t    pix_g;
	pcxt_pkg::color_t    pix_b;
	pcxt_pkg::color_t    out_r;
	pcxt_pkg::color_t    out_g;
	pcxt_pkg::color_t    out_b;
	pcxt_pkg::sample_t   opl_snd;
	pcxt_pkg::tandy_t    tandy_snd;
	logic                speaker;
	pcxt_pkg::sample_t   mix_out;
	logic                cpu_hold;

	// model of the control fields
	logic                m_skip;
	logic                m_mda;
	pcxt_pkg::tint_e     m_tint;

	integer              seed;
	int                  cycle_count = 0;

	pcxt_frontend #(
		.TICKS_PER_SECOND (TICKS)
	) pcxt_frontend_i (
		.CLOCK_27  (CLOCK_27),
		.reset     (reset),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.pix_r     (pix_r),
		.pix_g     (pix_g),
		.pix_b     (pix_b),
		.out_r     (out_r),
		.out_g     (out_g),
		.out_b     (out_b),
		.opl_snd   (opl_snd),
		.tandy_snd (tandy_snd),
		.speaker   (speaker),
		.mix_out   (mix_out),
		.cpu_hold  (cpu_hold)
	);

	// 50 MHz bench clock
	initial begin
		CLOCK_27 = 1'b0;
		forever #10 CLOCK_27 = ~CLOCK_27;
	end

	// run limit
	always @(posedge CLOCK_27) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout: the test did not finish within %0d cycles", MAX_CYCLES);
			$display(">>> FAIL");
			$fatal(1, "run limit reached");
		end
	end

	////////////////////
	// checks
	////////////////////
	task automatic report_error(input string msg);
		$display("[ERROR] %0t: %s", $time, msg);
		$display(">>> FAIL");
		$fatal(1, "check failed");
	endtask

	task automatic check_hold(input logic got, input logic exp, input string what);
		if (got !== exp)
			report_error($sformatf("%s: cpu_hold %b, expected %b", what, got, exp));
	endtask

	task automatic check_apb(input pcxt_pkg::apb_data_t got, input logic got_err,
		input pcxt_pkg::apb_data_t exp, input logic exp_err, input logic cmp_data,
		input string what);
		if (got_err !== exp_err)
			report_error($sformatf("%s: pslverr %b, expected %b", what, got_err, exp_err));
		if (cmp_data && (got !== exp))
			report_error($sformatf("%s: prdata %h, expected %h", what, got, exp));
	endtask

	task automatic check_color(input pcxt_pkg::color_t gr, input pcxt_pkg::color_t gg,
		input pcxt_pkg::color_t gb, input pcxt_pkg::color_t er,
		input pcxt_pkg::color_t eg, input pcxt_pkg::color_t eb);
		if ((gr !== er) || (gg !== eg) || (gb !== eb))
			report_error($sformatf("video: rgb %h/%h/%h, expected %h/%h/%h",
				gr, gg, gb, er, eg, eb));
	endtask

	task automatic check_sample(input pcxt_pkg::sample_t got, input pcxt_pkg::sample_t exp);
		if (got !== exp)
			report_error($sformatf("audio: mix_out %h, expected %h", got, exp));
	endtask

	////////////////////
	// model
	////////////////////
	task automatic expect_pixel(input pcxt_pkg::color_t r, input pcxt_pkg::color_t g,
		input pcxt_pkg::color_t b, output pcxt_pkg::color_t er,
		output pcxt_pkg::color_t eg, output pcxt_pkg::color_t eb);
		pcxt_pkg::color_t luma;
		// 6-bit wrapped sum of the weights
		luma = pcxt_pkg::RED_WEIGHT[r] + pcxt_pkg::GREEN_WEIGHT[g] + pcxt_pkg::BLUE_WEIGHT[b];
		er = r;
		eg = g;
		eb = b;
		if (m_mda && (m_tint == pcxt_pkg::TINT_GREEN)) begin
			er = '0;
			eg = luma;
			eb = '0;
		end else if (m_mda && (m_tint == pcxt_pkg::TINT_AMBER)) begin
			er = luma;
			eg = luma >> 1;
			eb = '0;
		end else if (m_mda && (m_tint == pcxt_pkg::TINT_BW)) begin
			er = luma;
			eg = luma;
			eb = luma;
		end
	endtask

	function automatic pcxt_pkg::sample_t expect_mix(input pcxt_pkg::sample_t opl,
		input pcxt_pkg::tandy_t tandy, input logic spk);
		logic signed [31:0] sum;
		// wide sum, bits 16:1 match the 17-bit sum
		sum = (int'(opl) <<< 2) + (int'(spk) <<< 15) + (int'(tandy) <<< 8);
		return pcxt_pkg::sample_t'(sum[16:1]);
	endfunction

	function automatic pcxt_pkg::apb_data_t expected_ctrl();
		pcxt_pkg::apb_data_t w;
		w = '0;
		w[pcxt_pkg::CTRL_SPLASH_SKIP] = m_skip;
		w[pcxt_pkg::CTRL_VIDEO_MDA] = m_mda;
		w[pcxt_pkg::CTRL_TINT_LSB +: 2] = m_tint;
		return w;
	endfunction

	// one apb transfer, setup then access
	task automatic apb_access(input logic write, input pcxt_pkg::apb_addr_t addr,
		input pcxt_pkg::apb_data_t data, output pcxt_pkg::apb_data_t rdata,
		output logic err);
		@(posedge CLOCK_27);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= write;
		paddr <= addr;
		pwdata <= data;
		@(posedge CLOCK_27);
		penable <= 1'b1;
		@(negedge CLOCK_27);
		rdata = prdata;
		err = pslverr;
		// zero wait states
		if (pready !== 1'b1)
			report_error("apb: pready low in the access phase");
		@(posedge CLOCK_27);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	////////////////////
	// sequence
	////////////////////
	initial begin
		int                  k;
		int                  n;
		int                  op;
		pcxt_pkg::apb_data_t rd;
		pcxt_pkg::apb_data_t exp_word;
		pcxt_pkg::apb_data_t d;
		pcxt_pkg::apb_addr_t a;
		logic                err;
		pcxt_pkg::color_t    r;
		pcxt_pkg::color_t    g;
		pcxt_pkg::color_t    bl;
		pcxt_pkg::color_t    er;
		pcxt_pkg::color_t    eg;
		pcxt_pkg::color_t    eb;
		pcxt_pkg::sample_t   opl;
		pcxt_pkg::sample_t   exp_mix;

		seed = 32'h8af2_1b56;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		pix_r = '0;
		pix_g = '0;
		pix_b = '0;
		opl_snd = '0;
		tandy_snd = '0;
		speaker = 1'b0;
		m_skip = 1'b0;
		m_mda = 1'b0;
		m_tint = pcxt_pkg::TINT_COLOR;
		repeat (10) @(posedge CLOCK_27);
		reset <= 1'b0;

		// splash from reset, status polled every other cycle
		for (k = 1; k <= SPLASH_CYCLES + 10; k++) begin
			@(posedge CLOCK_27);
			psel <= 1'b1;
			penable <= (k % 2 == 0);
			pwrite <= 1'b0;
			paddr <= pcxt_pkg::ADDR_STATUS;
			@(negedge CLOCK_27);
			check_hold(cpu_hold, k <= SPLASH_CYCLES, "splash after reset");
			if (k % 2 == 0) begin
				exp_word = '0;
				exp_word[0] = (k <= SPLASH_CYCLES);
				// timer stops once the splash ends
				exp_word[3:1] = ((k < SPLASH_CYCLES) ? k : SPLASH_CYCLES) / TICKS;
				check_apb(prdata, pslverr, exp_word, 1'b0, 1'b1, "status during splash");
			end
		end

		// soft reset, hold comes back the cycle after the pulse
		apb_access(1'b1, pcxt_pkg::ADDR_CTRL, 32'h1, rd, err);
		check_apb(rd, err, '0, 1'b0, 1'b0, "soft reset write");
		@(negedge CLOCK_27);
		check_hold(cpu_hold, 1'b0, "pulse cycle of soft reset");
		@(negedge CLOCK_27);
		check_hold(cpu_hold, 1'b1, "after soft reset");
		apb_access(1'b0, pcxt_pkg::ADDR_STATUS, '0, rd, err);
		check_apb(rd, err, 32'h1, 1'b0, 1'b1, "status after soft reset");

		// skip ends the splash early
		apb_access(1'b1, pcxt_pkg::ADDR_CTRL, 32'h2, rd, err);
		check_apb(rd, err, '0, 1'b0, 1'b0, "splash skip write");
		m_skip = 1'b1;
		@(negedge CLOCK_27);
		check_hold(cpu_hold, 1'b1, "cycle after skip write");
		@(negedge CLOCK_27);
		check_hold(cpu_hold, 1'b0, "after splash skip");

		// random register traffic
		for (n = 0; n < 40; n++) begin
			op = $unsigned($random(seed)) % 4;
			d = $random(seed);
			case (op)
				0: begin
					apb_access(1'b1, pcxt_pkg::ADDR_CTRL, d, rd, err);
					check_apb(rd, err, '0, 1'b0, 1'b0, "ctrl write");
					m_skip = d[pcxt_pkg::CTRL_SPLASH_SKIP];
					m_mda = d[pcxt_pkg::CTRL_VIDEO_MDA];
					m_tint = pcxt_pkg::tint_e'(d[pcxt_pkg::CTRL_TINT_LSB +: 2]);
				end
				1: begin
					apb_access(1'b0, pcxt_pkg::ADDR_CTRL, d, rd, err);
					check_apb(rd, err, expected_ctrl(), 1'b0, 1'b1, "ctrl read");
				end
				2: begin
					apb_access(1'b1, pcxt_pkg::ADDR_STATUS, d, rd, err);
					check_apb(rd, err, '0, 1'b1, 1'b0, "status write");
				end
				default: begin
					a = d[11:8];
					// nudge off the two mapped offsets
					if ((a == pcxt_pkg::ADDR_CTRL) || (a == pcxt_pkg::ADDR_STATUS))
						a = a ^ 4'h1;
					apb_access(d[12], a, d, rd, err);
					check_apb(rd, err, '0, 1'b1, 1'b0, "unmapped access");
				end
			endcase
		end

		// video, 8 batches of 38 pixels, first four sweep the tints
		for (n = 0; n < 8; n++) begin
			d = $random(seed);
			d[pcxt_pkg::CTRL_SOFT_RESET] = 1'b0;
			if (n < 4) begin
				d[pcxt_pkg::CTRL_VIDEO_MDA] = 1'b1;
				d[pcxt_pkg::CTRL_TINT_LSB +: 2] = n[1:0];
			end
			apb_access(1'b1, pcxt_pkg::ADDR_CTRL, d, rd, err);
			m_skip = d[pcxt_pkg::CTRL_SPLASH_SKIP];
			m_mda = d[pcxt_pkg::CTRL_VIDEO_MDA];
			m_tint = pcxt_pkg::tint_e'(d[pcxt_pkg::CTRL_TINT_LSB +: 2]);
			for (k = 0; k <= 38; k++) begin
				r = pcxt_pkg::color_t'($random(seed));
				g = pcxt_pkg::color_t'($random(seed));
				bl = pcxt_pkg::color_t'($random(seed));
				@(posedge CLOCK_27);
				pix_r <= r;
				pix_g <= g;
				pix_b <= bl;
				@(negedge CLOCK_27);
				// output holds the pixel from the edge before
				if (k > 0)
					check_color(out_r, out_g, out_b, er, eg, eb);
				expect_pixel(r, g, bl, er, eg, eb);
			end
		end

		// audio, odd steps force a negative opl2 sample
		for (k = 0; k <= 300; k++) begin
			opl = pcxt_pkg::sample_t'($random(seed));
			opl[15] = k[0];
			d = $random(seed);
			@(posedge CLOCK_27);
			opl_snd <= opl;
			tandy_snd <= d[7:0];
			speaker <= d[8];
			@(negedge CLOCK_27);
			if (k > 0)
				check_sample(mix_out, exp_mix);
			exp_mix = expect_mix(opl, d[7:0], d[8]);
		end

		$display(">>> PASS");
		$finish;
	end

endmodule

// File: verilog.f
rtl/pcxt_pkg.sv
rtl/cfg_regs.sv
rtl/splash_fsm.sv
rtl/second_timer.sv
rtl/mono_tint.sv
rtl/audio_mix.sv
rtl/pcxt_frontend.sv
bench/pcxt_frontend_tb.sv

// File: Bender.yml
package:
  name: pcxt_frontend

sources:
  - files:
      - rtl/pcxt_pkg.sv
      - rtl/cfg_regs.sv
      - rtl/splash_fsm.sv
      - rtl/second_timer.sv
      - rtl/mono_tint.sv
      - rtl/audio_mix.sv
      - rtl/pcxt_frontend.sv
  - target: test
    files:
      - bench/pcxt_frontend_tb.sv
